// ==== test/exec_cases.txt ====
# op rd rs1 rs2 imm use_imm | expected_rd expected_data (all hex)
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a lui b divu c remu
a 01 00 00 80000000 1 01 80000000
0 02 00 00 00000012 1 02 00000012
0 03 02 00 00000005 1 03 00000017
1 04 03 02 00000000 0 04 00000005
7 05 01 00 00000004 1 05 f8000000
6 06 01 00 00000004 1 06 08000000
5 07 02 00 00000003 1 07 00000090
8 08 01 02 00000000 0 08 00000001
9 09 01 02 00000000 0 09 00000000
4 0a 01 05 00000000 0 0a 78000000
3 0b 04 07 00000000 0 0b 00000095
2 0c 05 00 0f0f0f0f 1 0c 08000000
0 00 02 03 00000000 0 00 00000029
0 0d 00 02 00000000 0 0d 00000012
b 0e 0b 00 00000007 1 0e 00000015
0 0f 0e 00 00000001 1 0f 00000016
c 10 0b 00 00000007 1 10 00000002
b 11 02 00 00000000 0 11 ffffffff
c 12 02 00 00000000 0 12 00000012
8 13 11 02 00000000 0 13 00000001
7 14 05 04 00000000 0 14 ffc00000
1 15 00 03 00000000 0 15 ffffffe9
0 16 15 03 00000000 0 16 00000000
9 17 02 00 00000013 1 17 00000001

// ==== build.f ====
+incdir+hw
hw/exec_pkg.sv
hw/alu.sv
hw/divider.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/exec_core.sv
test/clock_gen.sv
test/exec_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary -f build.f --top-module exec_core_tb --Mdir obj_dir
./obj_dir/Vexec_core_tb > sim.log
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

// ==== test/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb import exec_pkg::*; ();

  localparam int MAX_CASES      = 64;
  localparam int READY_TIMEOUT  = 200;
  localparam int RESULT_TIMEOUT = 200;
  localparam int RESET_TIMEOUT  = 50;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  exec_op_t    in_op;
  reg_index_t  in_rd;
  reg_index_t  in_rs1;
  reg_index_t  in_rs2;
  word_t       in_imm;
  logic        in_use_imm;
  logic        result_valid;
  logic        result_ready;
  reg_index_t  result_rd;
  word_t       result_data;

  logic [31:0] fields [MAX_CASES][8]; // One row per line of the cases file.
  int          n_cases;
  int          checks;
  int          errors;
  int          failures;
  int          cycle = 0;
  int          first_issue_cycle;
  logic [31:0] lcg_state;

  clock_gen clock_gen (.clock(clock), .reset(reset));

  exec_core dut (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op), .in_rd(in_rd),
    .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm), .in_use_imm(in_use_imm),
    .result_valid(result_valid), .result_ready(result_ready),
    .result_rd(result_rd), .result_data(result_data)
  );

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // ************************************************************
  // Stimulus file
  // ************************************************************
  task automatic load_cases();
    int          fd;
    int          count;
    string       line;
    logic [31:0] f [8];
    n_cases = 0;
    fd = $fopen("test/exec_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/exec_cases.txt for reading.");
      failures++;
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      count = $fgets(line, fd);
      if (count > 0 && line[0] != "#") begin
        count = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (count == 8) begin
          fields[n_cases] = f;
          n_cases++;
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      $display("The cases file held no instructions.");
      failures++;
    end
  endtask

  // ************************************************************
  // Instruction driver and result monitor
  // ************************************************************
  task automatic drive_all();
    int waited;
    repeat (4) @(posedge clock); // Idle cycles in which result_valid must stay low.
    for (int i = 0; i < n_cases; i++) begin
      @(posedge clock);
      #1;
      in_valid   = 1'b1;
      in_op      = exec_op_t'(fields[i][0][3:0]);
      in_rd      = fields[i][1][4:0];
      in_rs1     = fields[i][2][4:0];
      in_rs2     = fields[i][3][4:0];
      in_imm     = fields[i][4];
      in_use_imm = fields[i][5][0];
      waited = 0;
      @(negedge clock);
      while (!in_ready && waited < READY_TIMEOUT) begin
        @(negedge clock);
        waited++;
      end
      if (!in_ready) begin
        $display("Instruction %0d was not accepted within %0d cycles.", i, READY_TIMEOUT);
        failures++;
        break;
      end
      if (i == 0) begin
        first_issue_cycle = cycle; // The transfer happens on the coming edge.
      end
    end
    @(posedge clock);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic collect_all();
    int          waited;
    logic        got;
    logic [31:0] r;
    for (int i = 0; i < n_cases; i++) begin
      waited = 0;
      got = 1'b0;
      while (!got && waited < RESULT_TIMEOUT) begin
        @(negedge clock);
        if (first_issue_cycle < 0) begin
          check_value("result_valid before the first transfer", 32'(result_valid), 32'd0);
        end
        if (result_valid && result_ready) begin
          got = 1'b1;
          if (i == 0) begin
            check_value("first result latency", 32'(cycle - first_issue_cycle), 32'd3);
          end
          check_value($sformatf("result %0d rd", i), 32'(result_rd), fields[i][6]);
          check_value($sformatf("result %0d data", i), result_data, fields[i][7]);
        end else begin
          waited++;
        end
        @(posedge clock);
        #1;
        if (got || i > 0) begin
          r = lcg_next();
          result_ready = (r[17:16] != 2'b00); // Low about one cycle in four.
        end
      end
      if (!got) begin
        $display("Result %0d did not arrive within %0d cycles.", i, RESULT_TIMEOUT);
        failures++;
        break;
      end
    end
    result_ready = 1'b1;
    repeat (10) begin
      @(negedge clock);
      check_value("result_valid after the last result", 32'(result_valid), 32'd0);
    end
  endtask

  initial begin
    int waited;
    in_valid          = 1'b0;
    in_op             = OP_ADD;
    in_rd             = '0;
    in_rs1            = '0;
    in_rs2            = '0;
    in_imm            = '0;
    in_use_imm        = 1'b0;
    result_ready      = 1'b1;
    checks            = 0;
    errors            = 0;
    failures          = 0;
    first_issue_cycle = -1;
    lcg_state         = 32'h14ee;
    load_cases();
    waited = 0;
    while (reset !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clock);
      waited++;
    end
    if (reset !== 1'b1) begin
      $display("Reset was never released.");
      failures++;
    end else if (n_cases > 0) begin
      fork
        drive_all();
        collect_all();
      join
    end
    $display("Checks: %0d, errors: %0d, other failures: %0d", checks, errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period.
  end

  initial begin
    reset = 1'b0;
    repeat (10) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_core import exec_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       in_valid,
  output logic       in_ready,
  input  exec_op_t   in_op,
  input  reg_index_t in_rd,
  input  reg_index_t in_rs1,
  input  reg_index_t in_rs2,
  input  word_t      in_imm,
  input  logic       in_use_imm,
  output logic       result_valid,
  input  logic       result_ready,
  output reg_index_t result_rd,
  output word_t      result_data
);

  logic       op_valid;
  logic       op_ready;
  exec_op_t   op_op;
  reg_index_t op_rd;
  word_t      op_src1;
  word_t      op_src2;
  logic       ex_valid;
  logic       ex_ready;
  reg_index_t ex_rd;
  word_t      ex_data;
  logic       wr_enable;
  reg_index_t wr_rd;
  word_t      wr_data;

  operand_stage u_operand (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op), .in_rd(in_rd),
    .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm), .in_use_imm(in_use_imm),
    .op_valid(op_valid), .op_ready(op_ready), .op_op(op_op), .op_rd(op_rd),
    .op_src1(op_src1), .op_src2(op_src2),
    .wr_enable(wr_enable), .wr_rd(wr_rd), .wr_data(wr_data)
  );

  execute_stage u_execute (
    .clock(clock), .reset(reset),
    .op_valid(op_valid), .op_ready(op_ready), .op_op(op_op), .op_rd(op_rd),
    .op_src1(op_src1), .op_src2(op_src2),
    .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_rd(ex_rd), .ex_data(ex_data)
  );

  writeback_stage u_writeback (
    .clock(clock), .reset(reset),
    .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_rd(ex_rd), .ex_data(ex_data),
    .result_valid(result_valid), .result_ready(result_ready),
    .result_rd(result_rd), .result_data(result_data),
    .wr_enable(wr_enable), .wr_rd(wr_rd), .wr_data(wr_data)
  );

endmodule

`default_nettype wire

// ==== hw/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module writeback_stage import exec_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       ex_valid,
  output logic       ex_ready,
  input  reg_index_t ex_rd,
  input  word_t      ex_data,
  output logic       result_valid,
  input  logic       result_ready,
  output reg_index_t result_rd,
  output word_t      result_data,
  output logic       wr_enable,
  output reg_index_t wr_rd,
  output word_t      wr_data
);

  logic take;

  assign ex_ready  = !result_valid || result_ready;
  assign take      = ex_valid && ex_ready;
  assign wr_enable = take && (ex_rd != {`REG_BITS{1'b0}}); // Commits in program order.
  assign wr_rd     = ex_rd;
  assign wr_data   = ex_data;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      result_valid <= 1'b0;
    end else if (take) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      result_rd   <= ex_rd;
      result_data <= ex_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execute_stage import exec_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       op_valid,
  output logic       op_ready,
  input  exec_op_t   op_op,
  input  reg_index_t op_rd,
  input  word_t      op_src1,
  input  word_t      op_src2,
  output logic       ex_valid,
  input  logic       ex_ready,
  output reg_index_t ex_rd,
  output word_t      ex_data
);

  word_t alu_result;
  word_t quotient;
  word_t remainder;
  logic  div_done;
  logic  div_start;
  logic  div_active;
  logic  div_rem;
  logic  is_div;
  logic  out_free;
  logic  accept;
  logic  div_finish;

  alu u_alu (
    .op(op_op),
    .src1(op_src1),
    .src2(op_src2),
    .result(alu_result)
  );

  divider u_divider (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .dividend(op_src1),
    .divisor(op_src2),
    .done(div_done),
    .quotient(quotient),
    .remainder(remainder)
  );

  // ************************************************************
  // Stage control and the division stall.
  // ************************************************************
  assign is_div     = (op_op == OP_DIVU) || (op_op == OP_REMU);
  assign out_free   = !ex_valid || ex_ready;
  assign op_ready   = out_free && !div_active;
  assign accept     = op_valid && op_ready;
  assign div_start  = accept && is_div;
  assign div_finish = div_active && div_done && out_free;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ex_valid   <= 1'b0;
      div_active <= 1'b0;
    end else begin
      if (div_start) begin
        div_active <= 1'b1;
      end else if (div_finish) begin
        div_active <= 1'b0;
      end
      if ((accept && !is_div) || div_finish) begin
        ex_valid <= 1'b1;
      end else if (ex_ready) begin
        ex_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ex_rd   <= op_rd;
      div_rem <= (op_op == OP_REMU);
    end
    if (accept && !is_div) begin
      ex_data <= alu_result;
    end else if (div_finish) begin
      ex_data <= div_rem ? remainder : quotient;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module operand_stage import exec_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       in_valid,
  output logic       in_ready,
  input  exec_op_t   in_op,
  input  reg_index_t in_rd,
  input  reg_index_t in_rs1,
  input  reg_index_t in_rs2,
  input  word_t      in_imm,
  input  logic       in_use_imm,
  output logic       op_valid,
  input  logic       op_ready,
  output exec_op_t   op_op,
  output reg_index_t op_rd,
  output word_t      op_src1,
  output word_t      op_src2,
  input  logic       wr_enable,
  input  reg_index_t wr_rd,
  input  word_t      wr_data
);

  word_t      regs [`REG_COUNT];
  reg_index_t rs1_q;
  reg_index_t rs2_q;
  logic       use_imm_q;
  word_t      src1_q;
  word_t      src2_q;
  logic       hit_in1;
  logic       hit_in2;
  logic       hit_q1;
  logic       hit_q2;
  word_t      read1;
  word_t      read2;

  assign in_ready = !op_valid || op_ready;

  // ************************************************************
  // Forwarding from the register write port.
  // ************************************************************
  assign hit_in1 = wr_enable && (in_rs1 != '0) && (wr_rd == in_rs1);
  assign hit_in2 = wr_enable && (in_rs2 != '0) && (wr_rd == in_rs2);
  assign hit_q1  = wr_enable && (rs1_q != '0) && (wr_rd == rs1_q);
  assign hit_q2  = wr_enable && (rs2_q != '0) && (wr_rd == rs2_q);

  assign read1 = hit_in1 ? wr_data : regs[in_rs1];
  assign read2 = hit_in2 ? wr_data : regs[in_rs2];

  assign op_src1 = hit_q1 ? wr_data : src1_q;
  assign op_src2 = (hit_q2 && !use_imm_q) ? wr_data : src2_q; // Immediates are never replaced.

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_enable && (wr_rd != '0)) begin
      regs[wr_rd] <= wr_data; // Entry zero is never written.
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      op_valid <= 1'b0;
    end else if (in_ready) begin
      op_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      op_op     <= in_op;
      op_rd     <= in_rd;
      rs1_q     <= in_rs1;
      rs2_q     <= in_rs2;
      use_imm_q <= in_use_imm;
      src1_q    <= read1;
      src2_q    <= in_use_imm ? in_imm : read2;
    end else begin
      src1_q <= op_src1; // A waiting instruction keeps its operands current.
      src2_q <= op_src2;
    end
  end

endmodule

`default_nettype wire

// ==== hw/divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module divider import exec_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  output logic  done,
  output word_t quotient,
  output word_t remainder
);

  localparam int CNT_BITS = $clog2(`XLEN);

  div_state_t           state;
  logic [CNT_BITS-1:0]  count;
  word_t                divisor_q;
  logic [`XLEN:0]       shifted;
  logic                 fits;

  // One restoring step brings down the next dividend bit.
  assign shifted = {remainder, quotient[`XLEN-1]};
  assign fits    = shifted >= {1'b0, divisor_q};
  assign done    = (state == DIV_DONE);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_BUSY: begin
          count <= count + 1'b1;
          if (count == CNT_BITS'(`XLEN - 1)) begin
            state <= DIV_DONE;
          end
        end
        default: begin
          if (start) begin
            state <= DIV_BUSY; // Done holds until the next start.
            count <= '0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start && (state != DIV_BUSY)) begin
      remainder <= '0;
      quotient  <= dividend;
      divisor_q <= divisor;
    end else if (state == DIV_BUSY) begin
      remainder <= fits ? shifted[`XLEN-1:0] - divisor_q : shifted[`XLEN-1:0];
      quotient  <= {quotient[`XLEN-2:0], fits};
    end
  end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu import exec_pkg::*; (
  input  exec_op_t op,
  input  word_t    src1,
  input  word_t    src2,
  output word_t    result
);

  localparam int SHIFT_BITS = $clog2(`XLEN);

  logic [SHIFT_BITS-1:0] shamt;
  logic                  less_signed;
  logic                  less_unsigned;

  assign shamt         = src2[SHIFT_BITS-1:0];
  assign less_signed   = $signed(src1) < $signed(src2);
  assign less_unsigned = src1 < src2;

  always_comb begin
    case (op)
      OP_ADD:  result = src1 + src2;
      OP_SUB:  result = src1 - src2;
      OP_AND:  result = src1 & src2;
      OP_OR:   result = src1 | src2;
      OP_XOR:  result = src1 ^ src2;
      OP_SLL:  result = src1 << shamt;
      OP_SRL:  result = src1 >> shamt;
      OP_SRA:  result = word_t'($signed(src1) >>> shamt); // Sign bit fills from the left.
      OP_SLT:  result = word_t'(less_signed);
      OP_SLTU: result = word_t'(less_unsigned);
      OP_LUI:  result = src2; // The upper immediate arrives as source 2.
      default: result = '0;   // Division results come from the divider.
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/exec_pkg.sv ====
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_BITS-1:0] reg_index_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_LUI  = 4'd10,
    OP_DIVU = 4'd11,
    OP_REMU = 4'd12
  } exec_op_t;

  typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_DONE} div_state_t;

endpackage

`default_nettype wire

// ==== hw/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Width of a data word and of every operand.
`define XLEN 32

// Number of integer registers, x0 included.
`define REG_COUNT 32

// Width of a register index.
`define REG_BITS 5

`endif
